//--- testbench/backend_vectors.txt
# stimulus: dv kind pc dest pred src_a src_b cdb_v cdb_tag cdb_value cdb_taken cdb_target
# expected: rv rdest rvalue squash redirect halt full opnd_a a_rdy opnd_b b_rdy (all hex)
1 0 100 01 0 00 00 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 1 0000 1
1 0 104 02 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 0 0000 1
1 0 108 03 0 02 01 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 0 0000 0
0 0 000 00 0 03 01 1 2 3333 0 000  0 00 0000 0 000 0 0 3333 1 0000 0
0 0 000 00 0 01 02 1 0 1111 0 000  1 01 1111 0 000 0 0 1111 1 0000 0
0 0 000 00 0 01 02 1 1 2222 0 000  1 02 2222 0 000 0 0 1111 1 2222 1
0 0 000 00 0 02 03 0 0 0000 0 000  1 03 3333 0 000 0 0 2222 1 3333 1
0 0 000 00 0 03 01 0 0 0000 0 000  0 00 0000 0 000 0 0 3333 1 1111 1
1 0 10c 04 0 04 00 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 0 0000 1
1 0 110 04 0 04 00 1 3 4444 0 000  1 04 4444 0 000 0 0 0000 0 0000 1
0 0 000 00 0 04 00 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 0 0000 1
0 0 000 00 0 04 04 1 4 5555 0 000  1 04 5555 0 000 0 0 5555 1 5555 1
0 0 000 00 0 04 00 0 0 0000 0 000  0 00 0000 0 000 0 0 5555 1 0000 1
1 1 200 05 0 00 00 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 1 0000 1
1 0 204 06 0 05 00 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 0 0000 1
0 0 000 00 0 06 05 1 6 6666 0 000  0 00 0000 0 000 0 0 6666 1 0000 0
0 0 000 00 0 06 05 1 5 0204 1 300  1 05 0204 1 300 0 0 6666 1 0204 1
0 0 000 00 0 06 05 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 1 0204 1
1 2 500 00 0 00 00 0 0 0000 0 000  1 00 0000 0 000 1 0 0000 1 0000 1
0 0 000 00 0 01 02 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 2222 1
1 0 400 08 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 0000 1
1 0 404 09 0 08 01 0 0 0000 0 000  0 00 0000 0 000 0 0 0000 0 1111 1
1 0 408 0a 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 0000 1
1 0 40c 0b 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 0000 1
1 0 410 0c 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 0000 1
1 0 414 0d 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 0000 1
1 0 418 0e 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 0 1111 1 0000 1
1 0 41c 0f 0 01 00 0 0 0000 0 000  0 00 0000 0 000 0 1 1111 1 0000 1
0 0 000 00 0 08 09 1 1 8888 0 000  1 08 8888 0 000 0 1 8888 1 0000 0
0 0 000 00 0 08 01 0 0 0000 0 000  0 00 0000 0 000 0 0 8888 1 1111 1
0 0 000 00 0 09 00 1 2 9999 0 000  1 09 9999 0 000 0 0 9999 1 0000 1
0 0 000 00 0 09 0a 0 0 0000 0 000  0 00 0000 0 000 0 0 9999 1 0000 0

//--- project.f
rtl/ooo_pkg.sv
rtl/rob.sv
rtl/rename_map.sv
rtl/arch_regfile.sv
rtl/ooo_backend_top.sv
testbench/tb_ooo_backend.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary -f project.f --top-module tb_ooo_backend -o sim_tb 2>&1 | tee sim.log &&
./obj_dir/sim_tb 2>&1 | tee -a sim.log &&
grep -q "STATUS: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

//--- testbench/tb_ooo_backend.sv
// needs testbench/backend_vectors.txt under the run directory; rob_depth is fixed at 8
`timescale 1ns/1ns

module tb_ooo_backend;
    import ooo_pkg::*;

    localparam int rob_depth    = 8;
    localparam int tag_w        = $clog2(rob_depth);
    localparam int reset_cycles = 2;
    localparam int max_vectors  = 64;
    localparam int n_fields     = 23;

    // vector file columns, stimulus then expected outputs
    localparam int c_dv = 0, c_kind = 1, c_pc = 2, c_dest = 3, c_pred = 4, c_sa = 5, c_sb = 6;
    localparam int c_cv = 7, c_ctag = 8, c_cval = 9, c_ctaken = 10, c_ctgt = 11;
    localparam int c_rv = 12, c_rdest = 13, c_rval = 14, c_sq = 15, c_redir = 16;
    localparam int c_halt = 17, c_full = 18, c_oa = 19, c_oar = 20, c_ob = 21, c_obr = 22;

    logic             clock;
    logic             reset;
    logic             dispatch_valid;
    inst_kind_t       dispatch_kind;
    word_t            dispatch_pc;
    reg_idx_t         dispatch_dest;
    logic             dispatch_pred_taken;
    reg_idx_t         src_a;
    reg_idx_t         src_b;
    logic             cdb_valid;
    logic [tag_w-1:0] cdb_tag;
    word_t            cdb_value;
    logic             cdb_taken;
    word_t            cdb_target;
    logic             full;
    logic             retire_valid;
    reg_idx_t         retire_dest;
    word_t            retire_value;
    logic             squash;
    word_t            redirect_pc;
    logic             halt;
    word_t            opnd_a;
    word_t            opnd_b;
    logic             opnd_a_ready;
    logic             opnd_b_ready;

    logic [31:0] vec_mem [max_vectors][n_fields];
    int          n_vectors    = 0;
    int          mismatches   = 0;
    int          other_errors = 0;
    int          cycles       = 0;
    int          limit        = 0;
    bit          loaded;

    ooo_backend_top #(.rob_depth(rob_depth)) dut0 (.*);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
    end

    ////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////

    task automatic check_word(string name, int idx, word_t expected, word_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s at vector %0d: expected %h, got %h", name, idx, expected, actual);
        end
    endtask

    task automatic check_reg(string name, int idx, reg_idx_t expected, reg_idx_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s at vector %0d: expected %h, got %h", name, idx, expected, actual);
        end
    endtask

    task automatic check_bit(string name, int idx, logic expected, logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s at vector %0d: expected %h, got %h", name, idx, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // vector file and stimulus
    ////////////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int          fd;
        int          got;
        int          line_no;
        string       line;
        logic [31:0] f [n_fields];
        line_no = 0;
        fd = $fopen("testbench/backend_vectors.txt", "r");
        if (fd == 0) begin
            $display("error: the vector file could not be opened");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // skip comments and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            got = $sscanf(line,
                          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                          f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                          f[20], f[21], f[22]);
            if (got != n_fields) begin
                $display("error: line %0d of the vector file has %0d fields", line_no, got);
                other_errors++;
            end else if (n_vectors == max_vectors) begin
                $display("error: the vector file holds more than %0d vectors", max_vectors);
                other_errors++;
            end else begin
                for (int k = 0; k < n_fields; k++) begin
                    vec_mem[n_vectors][k] = f[k];
                end
                n_vectors++;
            end
        end
        $fclose(fd);
        if (n_vectors == 0) begin
            $display("error: no vectors were read");
            other_errors++;
        end
    endtask

    task automatic drive_idle();
        dispatch_valid      = 1'b0;
        dispatch_kind       = kind_alu;
        dispatch_pc         = '0;
        dispatch_dest       = zero_reg;
        dispatch_pred_taken = 1'b0;
        src_a               = zero_reg;
        src_b               = zero_reg;
        cdb_valid           = 1'b0;
        cdb_tag             = '0;
        cdb_value           = '0;
        cdb_taken           = 1'b0;
        cdb_target          = '0;
    endtask

    task automatic apply_vector(int i);
        dispatch_valid      = vec_mem[i][c_dv][0];
        dispatch_kind       = inst_kind_t'(vec_mem[i][c_kind][1:0]);
        dispatch_pc         = vec_mem[i][c_pc];
        dispatch_dest       = vec_mem[i][c_dest][4:0];
        dispatch_pred_taken = vec_mem[i][c_pred][0];
        src_a               = vec_mem[i][c_sa][4:0];
        src_b               = vec_mem[i][c_sb][4:0];
        cdb_valid           = vec_mem[i][c_cv][0];
        cdb_tag             = vec_mem[i][c_ctag][tag_w-1:0];
        cdb_value           = vec_mem[i][c_cval];
        cdb_taken           = vec_mem[i][c_ctaken][0];
        cdb_target          = vec_mem[i][c_ctgt];
    endtask

    // payload fields only mean something when their valid or ready bit is set
    task automatic check_outputs(int i);
        check_bit("retire_valid", i, vec_mem[i][c_rv][0], retire_valid);
        if (vec_mem[i][c_rv][0]) begin
            check_reg("retire_dest", i, vec_mem[i][c_rdest][4:0], retire_dest);
            check_word("retire_value", i, vec_mem[i][c_rval], retire_value);
        end
        check_bit("squash", i, vec_mem[i][c_sq][0], squash);
        if (vec_mem[i][c_sq][0]) begin
            check_word("redirect_pc", i, vec_mem[i][c_redir], redirect_pc);
        end
        check_bit("halt", i, vec_mem[i][c_halt][0], halt);
        check_bit("full", i, vec_mem[i][c_full][0], full);
        check_bit("opnd_a_ready", i, vec_mem[i][c_oar][0], opnd_a_ready);
        if (vec_mem[i][c_oar][0]) begin
            check_word("opnd_a", i, vec_mem[i][c_oa], opnd_a);
        end
        check_bit("opnd_b_ready", i, vec_mem[i][c_obr][0], opnd_b_ready);
        if (vec_mem[i][c_obr][0]) begin
            check_word("opnd_b", i, vec_mem[i][c_ob], opnd_b);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////

    initial begin
        wait (loaded);
        while (cycles < limit) begin
            @(posedge clock);
        end
        $display("error: the run did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    // one vector per cycle, outputs compared after the rising edge
    initial begin
        reset = 1'b1;
        drive_idle();
        load_vectors();
        limit  = reset_cycles + n_vectors + 20;
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < n_vectors; i++) begin
            apply_vector(i);
            @(negedge clock);
            check_outputs(i);
        end
        drive_idle();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/ooo_backend_top.sv
// dispatch and cdb are strobes without back-pressure; halt must be dispatched with dest 0
`timescale 1ns/1ns

module ooo_backend_top #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  ooo_pkg::inst_kind_t dispatch_kind,
    input  ooo_pkg::word_t      dispatch_pc,
    input  ooo_pkg::reg_idx_t   dispatch_dest,
    input  logic                dispatch_pred_taken,
    input  ooo_pkg::reg_idx_t   src_a,
    input  ooo_pkg::reg_idx_t   src_b,
    input  logic                cdb_valid,
    input  logic [tag_w-1:0]    cdb_tag,
    input  ooo_pkg::word_t      cdb_value,
    input  logic                cdb_taken,
    input  ooo_pkg::word_t      cdb_target,
    output logic                full,
    output logic                retire_valid,
    output ooo_pkg::reg_idx_t   retire_dest,
    output ooo_pkg::word_t      retire_value,
    output logic                squash,
    output ooo_pkg::word_t      redirect_pc,
    output logic                halt,
    output ooo_pkg::word_t      opnd_a,
    output ooo_pkg::word_t      opnd_b,
    output logic                opnd_a_ready,
    output logic                opnd_b_ready
);
    import ooo_pkg::*;

    logic [tag_w-1:0] rob_tail;
    logic [tag_w-1:0] rob_head;
    logic [tag_w-1:0] look_tag_a;
    logic [tag_w-1:0] look_tag_b;
    logic             look_ready_a;
    logic             look_ready_b;
    word_t            look_value_a;
    word_t            look_value_b;
    reg_idx_t         rf_addr_a;
    reg_idx_t         rf_addr_b;
    word_t            rd_a;
    word_t            rd_b;

    rob #(.rob_depth(rob_depth)) rob0 (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_kind       (dispatch_kind),
        .dispatch_pc         (dispatch_pc),
        .dispatch_dest       (dispatch_dest),
        .dispatch_pred_taken (dispatch_pred_taken),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_value           (cdb_value),
        .cdb_taken           (cdb_taken),
        .cdb_target          (cdb_target),
        .look_tag_a          (look_tag_a),
        .look_tag_b          (look_tag_b),
        .rob_tail            (rob_tail),
        .rob_head            (rob_head),
        .full                (full),
        .retire_valid        (retire_valid),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .squash              (squash),
        .redirect_pc         (redirect_pc),
        .halt                (halt),
        .look_ready_a        (look_ready_a),
        .look_ready_b        (look_ready_b),
        .look_value_a        (look_value_a),
        .look_value_b        (look_value_b)
    );

    rename_map #(.rob_depth(rob_depth)) map0 (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .rob_tail       (rob_tail),
        .src_a          (src_a),
        .src_b          (src_b),
        .retire_valid   (retire_valid),
        .retire_dest    (retire_dest),
        .rob_head       (rob_head),
        .squash         (squash),
        .look_ready_a   (look_ready_a),
        .look_ready_b   (look_ready_b),
        .look_value_a   (look_value_a),
        .look_value_b   (look_value_b),
        .rd_a           (rd_a),
        .rd_b           (rd_b),
        .look_tag_a     (look_tag_a),
        .look_tag_b     (look_tag_b),
        .rf_addr_a      (rf_addr_a),
        .rf_addr_b      (rf_addr_b),
        .opnd_a         (opnd_a),
        .opnd_b         (opnd_b),
        .opnd_a_ready   (opnd_a_ready),
        .opnd_b_ready   (opnd_b_ready)
    );

    arch_regfile rf0 (
        .clock     (clock),
        .reset     (reset),
        .we        (retire_valid),
        .wr_addr   (retire_dest),
        .wr_data   (retire_value),
        .rf_addr_a (rf_addr_a),
        .rf_addr_b (rf_addr_b),
        .rd_a      (rd_a),
        .rd_b      (rd_b)
    );

endmodule

//--- rtl/arch_regfile.sv
// reads have no write bypass; a value retiring this cycle must come through the rob
`timescale 1ns/1ns

module arch_regfile (
    input  logic              clock,
    input  logic              reset,
    input  logic              we,
    input  ooo_pkg::reg_idx_t wr_addr,
    input  ooo_pkg::word_t    wr_data,
    input  ooo_pkg::reg_idx_t rf_addr_a,
    input  ooo_pkg::reg_idx_t rf_addr_b,
    output ooo_pkg::word_t    rd_a,
    output ooo_pkg::word_t    rd_b
);
    import ooo_pkg::*;

    word_t regs [32];

    // committed state, all zero out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != zero_reg)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // register 0 is hardwired
    assign rd_a = (rf_addr_a == zero_reg) ? '0 : regs[rf_addr_a];
    assign rd_b = (rf_addr_b == zero_reg) ? '0 : regs[rf_addr_b];

endmodule

//--- rtl/rename_map.sv
// records every dispatch with a nonzero dest, so halt must be dispatched with dest 0
`timescale 1ns/1ns

module rename_map #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  ooo_pkg::reg_idx_t dispatch_dest,
    input  logic [tag_w-1:0]  rob_tail,
    input  ooo_pkg::reg_idx_t src_a,
    input  ooo_pkg::reg_idx_t src_b,
    input  logic              retire_valid,
    input  ooo_pkg::reg_idx_t retire_dest,
    input  logic [tag_w-1:0]  rob_head,
    input  logic              squash,
    input  logic              look_ready_a,
    input  logic              look_ready_b,
    input  ooo_pkg::word_t    look_value_a,
    input  ooo_pkg::word_t    look_value_b,
    input  ooo_pkg::word_t    rd_a,
    input  ooo_pkg::word_t    rd_b,
    output logic [tag_w-1:0]  look_tag_a,
    output logic [tag_w-1:0]  look_tag_b,
    output ooo_pkg::reg_idx_t rf_addr_a,
    output ooo_pkg::reg_idx_t rf_addr_b,
    output ooo_pkg::word_t    opnd_a,
    output ooo_pkg::word_t    opnd_b,
    output logic              opnd_a_ready,
    output logic              opnd_b_ready
);
    import ooo_pkg::*;

    logic             pending [32];
    logic [tag_w-1:0] map_tag [32];
    logic             record;
    logic             release_ok;

    // picks the operand source, result is {ready, value}
    function automatic logic [32:0] resolve(reg_idx_t src, logic busy, logic look_ready,
                                            word_t look_value, word_t rf_value);
        logic [32:0] result;
        if (src == zero_reg) begin
            result = {1'b1, 32'd0};
        end else if (!busy) begin
            result = {1'b1, rf_value};
        end else begin
            result = {look_ready, look_value};
        end
        return result;
    endfunction

    assign record = dispatch_valid && (dispatch_dest != zero_reg);

    // only the youngest writer may clear the entry
    assign release_ok = retire_valid && pending[retire_dest] && (map_tag[retire_dest] == rob_head);

    // dispatch recording is last so it wins over a release
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < 32; i++) begin
                pending[i] <= 1'b0;
            end
        end else begin
            if (release_ok) begin
                pending[retire_dest] <= 1'b0;
            end
            if (record) begin
                pending[dispatch_dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (record) begin
            map_tag[dispatch_dest] <= rob_tail;
        end
    end

    assign look_tag_a = map_tag[src_a];
    assign look_tag_b = map_tag[src_b];
    assign rf_addr_a  = src_a;
    assign rf_addr_b  = src_b;

    assign {opnd_a_ready, opnd_a} = resolve(src_a, pending[src_a], look_ready_a, look_value_a, rd_a);
    assign {opnd_b_ready, opnd_b} = resolve(src_b, pending[src_b], look_ready_b, look_value_b, rd_b);

endmodule

//--- rtl/rob.sv
// rob_depth must be a power of two; no dispatch while full, halt entries are dispatched already done
`timescale 1ns/1ns

module rob #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  ooo_pkg::inst_kind_t dispatch_kind,
    input  ooo_pkg::word_t      dispatch_pc,
    input  ooo_pkg::reg_idx_t   dispatch_dest,
    input  logic                dispatch_pred_taken,
    input  logic                cdb_valid,
    input  logic [tag_w-1:0]    cdb_tag,
    input  ooo_pkg::word_t      cdb_value,
    input  logic                cdb_taken,
    input  ooo_pkg::word_t      cdb_target,
    input  logic [tag_w-1:0]    look_tag_a,
    input  logic [tag_w-1:0]    look_tag_b,
    output logic [tag_w-1:0]    rob_tail,
    output logic [tag_w-1:0]    rob_head,
    output logic                full,
    output logic                retire_valid,
    output ooo_pkg::reg_idx_t   retire_dest,
    output ooo_pkg::word_t      retire_value,
    output logic                squash,
    output ooo_pkg::word_t      redirect_pc,
    output logic                halt,
    output logic                look_ready_a,
    output logic                look_ready_b,
    output ooo_pkg::word_t      look_value_a,
    output ooo_pkg::word_t      look_value_b
);
    import ooo_pkg::*;

    // entry fields
    entry_state_t     state   [rob_depth];
    inst_kind_t       kind    [rob_depth];
    word_t            pc      [rob_depth];
    reg_idx_t         dest    [rob_depth];
    logic             pred    [rob_depth];
    logic             mispred [rob_depth];
    word_t            value   [rob_depth];
    word_t            target  [rob_depth];

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   count;
    logic             cdb_hit;

    assign rob_head = head;
    assign rob_tail = tail;
    assign full     = (count == (tag_w + 1)'(rob_depth));

    // late or stale completions are dropped
    assign cdb_hit = cdb_valid && (state[cdb_tag] == st_issued);

    //////////////////////////////////////////////////////////////////////
    // retire from the head
    //////////////////////////////////////////////////////////////////////

    assign retire_valid = (state[head] == st_done);
    assign retire_dest  = dest[head];
    assign retire_value = value[head];
    assign squash       = retire_valid && (kind[head] == kind_branch) && mispred[head];
    assign redirect_pc  = target[head];
    assign halt         = retire_valid && (kind[head] == kind_halt);

    // operand lookups for the rename map
    assign look_ready_a = (state[look_tag_a] == st_done);
    assign look_ready_b = (state[look_tag_b] == st_done);
    assign look_value_a = value[look_tag_a];
    assign look_value_b = value[look_tag_b];

    //////////////////////////////////////////////////////////////////////
    // pointers, count and entry state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                state[i] <= st_free;
            end
        end else begin
            if (retire_valid) begin
                state[head] <= st_free;
                head        <= head + tag_w'(1);
            end
            if (cdb_hit) begin
                state[cdb_tag] <= st_done;
            end
            // halt needs no execution
            if (dispatch_valid) begin
                state[tail] <= (dispatch_kind == kind_halt) ? st_done : st_issued;
                tail        <= tail + tag_w'(1);
            end
            case ({dispatch_valid, retire_valid})
                2'b10:   count <= count + (tag_w + 1)'(1);
                2'b01:   count <= count - (tag_w + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    // payload fields
    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            kind[tail]  <= dispatch_kind;
            pc[tail]    <= dispatch_pc;
            dest[tail]  <= (dispatch_kind == kind_halt) ? zero_reg : dispatch_dest;
            pred[tail]  <= dispatch_pred_taken;
            value[tail] <= '0;
        end
        if (cdb_hit) begin
            value[cdb_tag]   <= cdb_value;
            mispred[cdb_tag] <= (cdb_taken != pred[cdb_tag]);
            // resolved next pc, fall through when not taken
            target[cdb_tag]  <= cdb_taken ? cdb_target : pc[cdb_tag] + 32'd4;
        end
    end

    // a dispatch into a full buffer would overwrite the unretired head
    a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> !full);

    // the cdb must only name tags that are still in flight
    a_no_cdb_to_free: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (state[cdb_tag] != st_free));

endmodule

//--- rtl/ooo_pkg.sv
// shared types for the commit back end; words are 32 bits and there are 32 architectural registers
package ooo_pkg;

    //////////////////////////////////////////////////////////////////////
    // data and register types
    //////////////////////////////////////////////////////////////////////

    // data values and pcs
    typedef logic [31:0] word_t;

    // architectural register index, register 0 is never written
    typedef logic [4:0] reg_idx_t;

    localparam reg_idx_t zero_reg = 5'd0;

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    // what the rob must do at retire
    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_branch = 2'd1,
        kind_halt   = 2'd2
    } inst_kind_t;

    // life of one rob entry
    // free -> issued at dispatch, issued -> done on the cdb, done -> free at retire
    typedef enum logic [1:0] {
        st_free   = 2'd0,
        st_issued = 2'd1,
        st_done   = 2'd2
    } entry_state_t;

endpackage
